// File: Makefile
TOP := tb_rx_path
OBJ := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Ilogic --top-module rx_path_top \
	  logic/rx_frame_pkg.sv logic/rx_check_pkg.sv logic/rx_frame_sync.sv \
	  logic/rx_fifo.sv logic/test_mode_check.sv logic/rx_path_top.sv

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) --Mdir $(OBJ) -o $(TOP)
	-./$(OBJ)/$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf $(OBJ) sim.log

// File: logic/rx_check_pkg.sv
// types for the FIFO write port and the test-mode checker
`default_nettype none

package rx_check_pkg;

  // checker states, it follows the frame sync into test mode
  typedef enum logic [2:0] {
    TMC_IDLE   = 3'd0,  // waiting for a frame to start
    TMC_12_CHK = 3'd1,  // frame sync is on C1C2
    TMC_34_CHK = 3'd2,  // frame sync is on C3C4
    TMC_CNT    = 3'd3,  // one cycle to load the skip count
    TMC_GO     = 3'd4   // sequence checking active
  } tmc_state_t;

  // RX FIFO write port
  typedef struct packed {
    logic        en;    // write strobe, dropped by the FIFO when full
    logic [15:0] data;  // payload word
  } fifo_wr_t;

endpackage

`default_nettype wire

// File: logic/rx_fifo.sv
// synchronous RX FIFO with registered read data
// a write while full is dropped, even if a read happens in the same cycle
// a read while empty is ignored and rd_data keeps its old value
// rd_data is valid the cycle after an accepted read, used updates the cycle after a change
`timescale 1ns/1ps
`default_nettype none
`include "rx_settings.svh"

module rx_fifo
  import rx_check_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  fifo_wr_t              wr,
  input  logic                  rd_en,
  output logic [15:0]           rd_data,
  output logic [`RX_USED_W-1:0] used
);

  localparam int unsigned DEPTH = `RX_FIFO_DEPTH;
  localparam int unsigned AW    = $clog2(DEPTH);
  localparam int unsigned UW    = `RX_USED_W;

  logic [15:0]   mem [DEPTH];  // inferred block RAM
  logic [AW-1:0] wr_ptr;       // wraps naturally as DEPTH is a power of two
  logic [AW-1:0] rd_ptr;
  logic          full;
  logic          empty;
  logic          do_wr;        // write that is actually stored
  logic          do_rd;        // read that actually pops a word

  assign full  = (used == UW'(DEPTH));
  assign empty = (used == '0);
  assign do_wr = wr.en && !full;
  assign do_rd = rd_en && !empty;

  // storage and read register carry no reset
  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr.data;
    if (do_rd)
      rd_data <= mem[rd_ptr];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   used <= used + 1'b1;  // write only
        2'b01:   used <= used - 1'b1;  // read only
        default: used <= used;         // none, or both cancel out
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/rx_frame_pkg.sv
// types for the input side of the receive path
// the sync_state_t encoding is also watched by the test-mode checker
`default_nettype none

package rx_frame_pkg;

  // frame synchronizer states
  typedef enum logic [2:0] {
    SYNC_IDLE   = 3'd0,  // hunting for the sync word
    SYNC_START  = 3'd1,  // sync word seen, lasts one cycle
    SYNC_RX_1_2 = 3'd2,  // waiting for control word C1C2
    SYNC_RX_3_4 = 3'd3,  // waiting for control word C3C4
    SYNC_RX     = 3'd4,  // payload words go to the RX FIFO
    SYNC_FINISH = 3'd5   // frame done, back to hunting next cycle
  } sync_state_t;

  // one word from the host, no ready so it is taken whenever valid is high
  typedef struct packed {
    logic [15:0] data;   // host word
    logic        valid;  // word present this cycle
  } rx_word_t;

endpackage

`default_nettype wire

// File: logic/rx_frame_sync.sv
// frame synchronizer for the host word stream
// the sync word is only looked for while hunting, so payload equal to it is harmless
// a word arriving in SYNC_START or SYNC_FINISH is not examined, so the host leaves
// at least one idle cycle after the sync word and after the last payload word
// control words are stepped over without decoding
`timescale 1ns/1ps
`default_nettype none
`include "rx_settings.svh"

module rx_frame_sync
  import rx_frame_pkg::*, rx_check_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  rx_word_t    in_word,
  output sync_state_t sync_state,
  output fifo_wr_t    fifo_wr
);

  localparam int unsigned CNT_W = $clog2(`RX_FRAME_WORDS);

  sync_state_t      state_next;
  logic [CNT_W-1:0] word_cnt;   // payload words taken so far in this frame
  logic             last_word;  // current payload word ends the frame

  assign last_word = (word_cnt == CNT_W'(`RX_FRAME_WORDS - 1));

  always_comb
  begin
    state_next = sync_state;  // hold unless a word moves us on
    case (sync_state)
      SYNC_IDLE:
      begin
        if (in_word.valid && (in_word.data == `RX_SYNC_WORD))
          state_next = SYNC_START;
      end
      SYNC_START:
        state_next = SYNC_RX_1_2;  // one cycle marker for the start of a frame
      SYNC_RX_1_2:
      begin
        if (in_word.valid)
          state_next = SYNC_RX_3_4;  // C1C2 consumed
      end
      SYNC_RX_3_4:
      begin
        if (in_word.valid)
          state_next = SYNC_RX;  // C3C4 consumed, payload follows
      end
      SYNC_RX:
      begin
        if (in_word.valid && last_word)
          state_next = SYNC_FINISH;
      end
      SYNC_FINISH:
        state_next = SYNC_IDLE;
      default:
        state_next = SYNC_IDLE;  // recover from an unused encoding
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      sync_state <= SYNC_IDLE;
    else
      sync_state <= state_next;
  end

  // the counter sits at zero outside the payload, so each frame starts clean
  always_ff @(posedge clk)
  begin
    if (rst || (sync_state != SYNC_RX))
      word_cnt <= '0;
    else if (in_word.valid)
      word_cnt <= word_cnt + 1'b1;
  end

  // each payload word becomes a FIFO write one cycle later
  always_ff @(posedge clk)
  begin
    if (rst)
      fifo_wr.en <= 1'b0;
    else
      fifo_wr.en <= (sync_state == SYNC_RX) && in_word.valid;
    fifo_wr.data <= in_word.data;  // only meaningful while en is high
  end

endmodule

`default_nettype wire

// File: logic/rx_path_top.sv
// receive path top: frame sync, RX FIFO and test-mode checker
// the input cannot be stalled, rd_en is the only flow control on the read side
// all blocks share one clock, no domain crossing is done here
`timescale 1ns/1ps
`default_nettype none
`include "rx_settings.svh"

module rx_path_top
  import rx_frame_pkg::*, rx_check_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  rx_word_t              in_word,
  input  logic                  rd_en,
  output logic [15:0]           rd_data,
  output logic [`RX_USED_W-1:0] used,
  input  logic                  xrdy,
  input  logic                  lr_sync,
  output logic                  tmc_err
);

  sync_state_t sync_state;  // frame position, watched by the checker
  fifo_wr_t    fifo_wr;     // payload write into the FIFO

  rx_frame_sync u_frame_sync (
    .clk        (clk),
    .rst        (rst),
    .in_word    (in_word),
    .sync_state (sync_state),
    .fifo_wr    (fifo_wr)
  );

  rx_fifo u_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr      (fifo_wr),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .used    (used)
  );

  test_mode_check u_check (
    .clk        (clk),
    .rst        (rst),
    .sync_state (sync_state),
    .wr         (fifo_wr),
    .rd_en      (rd_en),
    .rd_data    (rd_data),
    .used       (used),
    .xrdy       (xrdy),
    .lr_sync    (lr_sync),
    .tmc_err    (tmc_err)
  );

endmodule

`default_nettype wire

// File: logic/rx_settings.svh
// build-wide constants for the receive path
// RX_FIFO_DEPTH must be a power of two and RX_USED_W must be able to count a full FIFO
// RX_SEQ_LAST stays below 256 since test-mode words carry a zero upper byte
`ifndef RX_SETTINGS_SVH
`define RX_SETTINGS_SVH

`define RX_SYNC_WORD   16'h7F7F  // first word of every frame
`define RX_FRAME_WORDS 60        // payload words that follow the two control words
`define RX_FIFO_DEPTH  4096      // RX FIFO entries
`define RX_USED_W      13        // occupancy count width, one bit more than the address
`define RX_SEQ_LAST    252       // test-mode count runs 1 up to this value and wraps to 1
`define RX_WD_W        16        // strobe watchdog width, its top bit flags a lost strobe

`endif

// File: logic/test_mode_check.sv
// test-mode sequence checker on both sides of the RX FIFO
// test mode is assumed once a frame is seen, the control words are not inspected
// checking expects the count to restart at 1 with the first payload word of the
// frame that arms it, also when it re-arms after an error
// words already queued when checking starts are skipped on the read side
// tmc_err is high before the first frame, after a mismatch, or while a strobe is missing
`timescale 1ns/1ps
`default_nettype none
`include "rx_settings.svh"

module test_mode_check
  import rx_frame_pkg::*, rx_check_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  sync_state_t           sync_state,
  input  fifo_wr_t              wr,
  input  logic                  rd_en,
  input  logic [15:0]           rd_data,
  input  logic [`RX_USED_W-1:0] used,
  input  logic                  xrdy,
  input  logic                  lr_sync,
  output logic                  tmc_err
);

  localparam int unsigned SEQ_W = $clog2(`RX_SEQ_LAST + 1);
  localparam int unsigned UW    = `RX_USED_W;
  localparam int unsigned WD_W  = `RX_WD_W;

  tmc_state_t       tmc_state;
  tmc_state_t       tmc_state_next;
  logic             rd_ok;        // read the FIFO will accept
  logic             rd_chk_dly;   // rd_data now holds a word that must match
  logic [UW-1:0]    skip_cnt;     // old words still ahead of the test-mode data
  logic             in_active;    // window where FIFO writes are checked
  logic [SEQ_W-1:0] seq_in_cnt;   // expected value of the next FIFO write
  logic [SEQ_W-1:0] seq_out_cnt;  // expected value of the next checked read
  logic             seq_err;
  logic [1:0]       strobe;       // bit 0 xrdy, bit 1 lr_sync
  logic [1:0]       strobe_dly;
  logic [WD_W-1:0]  wd_cnt [2];   // cycles since the last rising edge
  logic             wd_err;

  // count sequence 1 .. RX_SEQ_LAST, then back to 1
  function automatic logic [SEQ_W-1:0] seq_next(input logic [SEQ_W-1:0] cnt);
    if (cnt == SEQ_W'(`RX_SEQ_LAST))
      return SEQ_W'(1);
    return cnt + 1'b1;
  endfunction

  assign rd_ok     = rd_en && (used != '0);
  // the first payload write can land in TMC_CNT when the host sends without gaps
  assign in_active = (tmc_state == TMC_CNT) || (tmc_state == TMC_GO);
  assign strobe    = {lr_sync, xrdy};
  assign wd_err    = wd_cnt[0][WD_W-1] || wd_cnt[1][WD_W-1];
  assign tmc_err   = (tmc_state != TMC_GO) || wd_err;

  // watchdogs clear on a rising edge and stop once the top bit is set
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      strobe_dly <= '0;
      wd_cnt[0]  <= '0;
      wd_cnt[1]  <= '0;
    end
    else
    begin
      strobe_dly <= strobe;
      for (int i = 0; i < 2; i++)
      begin
        if (strobe[i] && !strobe_dly[i])
          wd_cnt[i] <= '0;
        else if (!wd_cnt[i][WD_W-1])
          wd_cnt[i] <= wd_cnt[i] + 1'b1;
      end
    end
  end

  always_comb
  begin
    tmc_state_next = tmc_state;
    case (tmc_state)
      TMC_IDLE:
      begin
        if (sync_state == SYNC_RX_1_2)
          tmc_state_next = TMC_12_CHK;  // a frame has started
      end
      TMC_12_CHK:
      begin
        if (sync_state != SYNC_RX_1_2)
          tmc_state_next = TMC_34_CHK;
      end
      TMC_34_CHK:
      begin
        if (sync_state != SYNC_RX_3_4)
          tmc_state_next = TMC_CNT;  // payload is starting
      end
      TMC_CNT:
        tmc_state_next = TMC_GO;
      TMC_GO:
      begin
        if (seq_err)
          tmc_state_next = TMC_IDLE;  // wait for a new frame to re-arm
      end
      default:
        tmc_state_next = TMC_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      tmc_state <= TMC_IDLE;
    else
      tmc_state <= tmc_state_next;
  end

  // used holds only old words in TMC_CNT, a read in that cycle pops one of them
  always_ff @(posedge clk)
  begin
    if (rst)
      skip_cnt <= '0;
    else if (tmc_state == TMC_CNT)
      skip_cnt <= used - UW'(rd_ok);
    else if (rd_ok && (skip_cnt != '0))
      skip_cnt <= skip_cnt - 1'b1;
  end

  // a read made while nothing is left to skip returns test-mode data next cycle
  always_ff @(posedge clk)
  begin
    if (rst)
      rd_chk_dly <= 1'b0;
    else
      rd_chk_dly <= rd_ok && (skip_cnt == '0) && (tmc_state == TMC_GO);
  end

  always_ff @(posedge clk)
  begin
    if (rst || !in_active)
      seq_in_cnt <= SEQ_W'(1);
    else if (wr.en)
      seq_in_cnt <= seq_next(seq_in_cnt);
  end

  always_ff @(posedge clk)
  begin
    if (rst || (tmc_state != TMC_GO))
      seq_out_cnt <= SEQ_W'(1);
    else if (rd_chk_dly)
      seq_out_cnt <= seq_next(seq_out_cnt);
  end

  // upper byte must be zero, so compare against the zero-extended count
  always_ff @(posedge clk)
  begin
    if (rst || !in_active)
      seq_err <= 1'b0;
    else if (wr.en && (wr.data != 16'(seq_in_cnt)))
      seq_err <= 1'b1;
    else if ((tmc_state == TMC_GO) && rd_chk_dly && (rd_data != 16'(seq_out_cnt)))
      seq_err <= 1'b1;
    else
      seq_err <= 1'b0;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+logic
logic/rx_frame_pkg.sv
logic/rx_check_pkg.sv
logic/rx_frame_sync.sv
logic/rx_fifo.sv
logic/test_mode_check.sv
logic/rx_path_top.sv
tests/tb_rx_path.sv

// File: tests/tb_rx_path.sv
// directed testbench for the receive path in test mode
// frames go in with random idle gaps, the RX FIFO is drained through rd_en
// expected read data sits in a queue that is filled as frames are sent
// the checker restarts its count at 1 whenever it re-arms, so the model does too
// xrdy and lr_sync toggle every 500 cycles unless a test holds lr_sync
`timescale 1ns/1ps
`default_nettype none
`include "rx_settings.svh"

module tb_rx_path
  import rx_frame_pkg::*, rx_check_pkg::*;
();

  localparam int STROBE_HALF = 500;    // cycles between strobe toggles
  localparam int STROBE_STOP = 33000;  // longer than the 32768 cycle watchdog limit
  localparam int FRAME_CYC   = (`RX_FRAME_WORDS + 3) * 5;  // words plus gaps of up to 3 cycles
  localparam int READ_CYC    = 12;     // one read with its share of burst pauses
  localparam int RUN_CYC     = 10 + 9 * FRAME_CYC + 540 * READ_CYC + STROBE_STOP + 3 * STROBE_HALF;
  localparam int TIMEOUT_CYC = 2 * RUN_CYC;

  logic                  clk;
  logic                  rst;
  rx_word_t              in_word;
  logic                  rd_en;
  logic [15:0]           rd_data;
  logic [`RX_USED_W-1:0] used;
  logic                  xrdy;
  logic                  lr_sync;
  logic                  tmc_err;

  integer      seed = 32'h87eb;
  int          tx_cnt;      // next test-mode count to send
  int          fail_cnt;
  logic [15:0] exp_q [$];   // words expected on the read side, oldest first
  bit          lr_stop;     // holds lr_sync where it is
  bit          watch_low;   // tmc_err must stay low while this is set
  string       watch_name;

  rx_path_top u_dut (
    .clk     (clk),
    .rst     (rst),
    .in_word (in_word),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .used    (used),
    .xrdy    (xrdy),
    .lr_sync (lr_sync),
    .tmc_err (tmc_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // periodic strobes, lr_sync can be frozen to starve its watchdog
  initial
  begin
    @(negedge rst);
    forever
    begin
      repeat (STROBE_HALF) @(posedge clk);
      xrdy <= ~xrdy;
      if (!lr_stop)
        lr_sync <= ~lr_sync;
    end
  end

  initial
  begin
    tmc_state_t state;
    repeat (TIMEOUT_CYC) @(posedge clk);
    state = u_dut.u_check.tmc_state;
    $display("timeout: tests still running after %0d cycles, checker state %s",
             TIMEOUT_CYC, state.name());
    $display("Something failed");
    $fatal(1, "run stopped by the timeout");
  end

  always @(negedge clk)
  begin
    if (watch_low)
      check_value(watch_name, 32'd0, 32'(tmc_err));  // tmc_err settles well before negedge
  end

  function automatic int rand_below(input int limit);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % limit;
  endfunction

  // test-mode count runs 1 up to the last value and wraps to 1
  function automatic int advance_count(input int count);
    return (count == `RX_SEQ_LAST) ? 1 : count + 1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      fail_cnt++;
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("Something failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // one word for one cycle, then gap idle cycles
  task automatic drive_word(input logic [15:0] word, input int gap);
    @(posedge clk);
    in_word <= '{data: word, valid: 1'b1};
    repeat (gap)
    begin
      @(posedge clk);
      in_word <= '{data: 16'h0000, valid: 1'b0};
    end
  endtask

  // sync, two control words, then payload from the model count or junk
  task automatic send_frame(input int bad_idx, input bit junk);
    logic [15:0] word;
    drive_word(`RX_SYNC_WORD, 1 + rand_below(4));  // the word right after sync is not looked at
    drive_word(16'hC1C2, rand_below(4));
    drive_word(16'hC3C4, rand_below(4));
    for (int i = 0; i < `RX_FRAME_WORDS; i++)
    begin
      if (junk)
        word = 16'hA500 | 16'(i);  // nonzero upper byte never matches a count
      else
      begin
        word   = 16'(tx_cnt);
        tx_cnt = advance_count(tx_cnt);
      end
      if (i == bad_idx)
        word = 16'hBAD0;  // the slot still uses up a count
      exp_q.push_back(word);
      drive_word(word, (i == `RX_FRAME_WORDS - 1) ? 1 + rand_below(4) : rand_below(4));
    end
  endtask

  // waits for a word in the FIFO, pops it and returns the registered read data
  task automatic read_word(output logic [15:0] data);
    @(negedge clk);
    while (used == '0)
      @(negedge clk);
    @(posedge clk);
    rd_en <= 1'b1;
    @(posedge clk);
    rd_en <= 1'b0;
    @(negedge clk);
    data = rd_data;
  endtask

  task automatic read_words(input string name, input int n);
    logic [15:0] data;
    logic [15:0] expected;
    repeat (n)
    begin
      read_word(data);
      expected = exp_q.pop_front();
      check_value(name, 32'(expected), 32'(data));
    end
  endtask

  task automatic drain_in_bursts(input string name, input int n);
    int left;
    int burst;
    left = n;
    while (left > 0)
    begin
      burst = 1 + rand_below(16);
      if (burst > left)
        burst = left;
      read_words(name, burst);
      left = left - burst;
      repeat (rand_below(8)) @(posedge clk);  // pause between bursts
    end
  endtask

  task automatic test_after_reset();
    @(negedge clk);
    check_value("after_reset tmc_err", 32'd1, 32'(tmc_err));
    check_value("after_reset used", 32'd0, 32'(used));
  endtask

  task automatic test_good_stream();
    tx_cnt = 1;  // first frame arms the checker on count 1
    fork
      begin
        send_frame(-1, 1'b0);
        watch_name = "good_stream tmc_err";
        watch_low  = 1'b1;  // checker is in its checking state by now
        send_frame(-1, 1'b0);
        send_frame(-1, 1'b0);
      end
      drain_in_bursts("good_stream data", 3 * `RX_FRAME_WORDS);
    join
  endtask

  task automatic test_occupancy();
    send_frame(-1, 1'b0);
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_value("occupancy full frame", 32'(`RX_FRAME_WORDS), 32'(used));
    read_words("occupancy data", 20);
    @(negedge clk);
    check_value("occupancy after reads", 32'(`RX_FRAME_WORDS - 20), 32'(used));
    read_words("occupancy data", `RX_FRAME_WORDS - 20);
  endtask

  task automatic test_corrupt_word();
    watch_low = 1'b0;
    send_frame(17, 1'b0);
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("corrupt tmc_err", 32'd1, 32'(tmc_err));
    read_words("corrupt drain", `RX_FRAME_WORDS);
    tx_cnt = 1;  // re-arming restarts the checker's count
    send_frame(-1, 1'b0);
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("corrupt recovered tmc_err", 32'd0, 32'(tmc_err));
    read_words("corrupt recovered data", `RX_FRAME_WORDS);
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("corrupt recovered read side", 32'd0, 32'(tmc_err));
  endtask

  task automatic test_pre_queued();
    send_frame(-1, 1'b1);  // first junk write drops the checker back to idle
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("pre_queued junk tmc_err", 32'd1, 32'(tmc_err));
    tx_cnt = 1;
    send_frame(-1, 1'b0);  // arms with the junk still queued ahead
    repeat (3) @(posedge clk);
    watch_name = "pre_queued tmc_err";
    watch_low  = 1'b1;
    read_words("pre_queued data", 2 * `RX_FRAME_WORDS);
    repeat (3) @(posedge clk);
    watch_low = 1'b0;
  endtask

  task automatic test_missing_strobe();
    lr_stop = 1'b1;
    repeat (STROBE_STOP) @(posedge clk);
    @(negedge clk);
    check_value("missing_strobe tmc_err", 32'd1, 32'(tmc_err));
    lr_stop = 1'b0;
    @(posedge lr_sync);  // the edge that clears the watchdog
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("strobe back tmc_err", 32'd0, 32'(tmc_err));
    @(posedge clk);
    watch_name = "strobe back stream tmc_err";
    watch_low  = 1'b1;
    send_frame(-1, 1'b0);  // count carries on from the previous frame
    read_words("strobe back data", `RX_FRAME_WORDS);
    repeat (3) @(posedge clk);
    watch_low = 1'b0;
  endtask

  initial
  begin
    rst        = 1'b1;
    in_word    = '0;
    rd_en      = 1'b0;
    xrdy       = 1'b0;
    lr_sync    = 1'b0;
    lr_stop    = 1'b0;
    watch_low  = 1'b0;
    watch_name = "";
    fail_cnt   = 0;
    tx_cnt     = 1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    test_after_reset();
    test_good_stream();
    test_occupancy();
    test_corrupt_word();
    test_pre_queued();
    test_missing_strobe();
    if (fail_cnt == 0)
    begin
      $display("Everything OK");
      $finish;
    end
    else
    begin
      $display("Something failed");
      $fatal(1, "checks reported mismatches");
    end
  end

endmodule

`default_nettype wire
